//--- core_top.f
+incdir+.
rv32i_isa_pkg.sv
core_pipe_pkg.sv
insn_buffer.sv
decode.sv
control.sv
regfile.sv
alu.sv
exec_stage.sv
core_top.sv
tb_core_top.sv

//--- Makefile
# Verilator flow for the RV32I decode and execute core
SIM      := verilator
FLAGS    := --binary --timing --assert
LINT     := --lint-only --timing --assert
TOP      := tb_core_top
FILELIST := core_top.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT) -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tb_core_top.sv
`timescale 1ns/100ps
// Testbench for the core: random legal RV32I stream, in-order reference model
// x31 is loaded once and kept as the JALR base, random writes never target it
// Loads and stores use x0 as base, word offsets inside the data memory
`include "core_settings.svh"

module tb_core_top;

    localparam int DEPTH   = `CORE_IN_DEPTH;
    localparam int RET     = `CORE_RET_CREDITS;
    localparam int MAW     = $clog2(`CORE_DMEM_WORDS);
    localparam int N_INSNS = 400;
    localparam logic [31:0] LUI_X31 = {20'h00001, 5'd31, 7'b0110111};  // x31 = 0x1000

    logic        clk = 1'b0;
    logic        reset_i = 1'b1;
    logic        insn_valid_i = 1'b0;
    logic [31:0] insn_pc_i = '0;
    logic [31:0] insn_i = '0;
    logic        retire_credit_i = 1'b0;
    logic        insn_credit_o, retire_valid_o, retire_we_o, retire_mem_we_o;
    logic [31:0] retire_pc_o, retire_next_pc_o, retire_wdata_o;
    logic [31:0] retire_mem_addr_o, retire_mem_wdata_o;
    logic [4:0]  retire_rd_o;

    integer      seed = 32'h29fb_ff14;
    int          value_errs, flow_errs, timeout_errs;
    int          issued, retired, in_credits, ret_credits, idle_cycles;
    logic        seen_accept;                 // First instruction taken
    logic [31:0] fetch_pc;
    logic [31:0] exp_pc_q [$];                // Issue order
    logic [31:0] exp_insn_q [$];
    int          credit_dly [$];              // Pending retire credit delays
    logic [31:0] mregs [32];                  // Model register file
    logic [31:0] mmem [`CORE_DMEM_WORDS];     // Model data memory

    core_top i_core_top (
        .clk, .reset_i, .insn_valid_i, .insn_pc_i, .insn_i, .insn_credit_o,
        .retire_valid_o, .retire_pc_o, .retire_next_pc_o, .retire_rd_o,
        .retire_we_o, .retire_wdata_o, .retire_mem_we_o, .retire_mem_addr_o,
        .retire_mem_wdata_o, .retire_credit_i
    );

    initial begin
        forever #50 clk = ~clk;  // 100 ns period
    end

    function automatic logic [31:0] rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_word(input logic [31:0] pc, input string what,
                              input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("FAIL %0t: pc %h %s is %h, expected %h", $time, pc, what, got, exp);
        end
    endtask

    task automatic flow_error(input string msg);
        flow_errs++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // ISA level ALU; alt selects SUB or SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = {31'b0, $signed(a) < $signed(b)};
            3'b011:  r = {31'b0, a < b};
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else     r = a >> b[4:0];
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] gen_insn();
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [20:0] imm21;
        logic [31:0] w;
        rd    = 5'(rnd(31));    // Never x31
        rs1   = 5'(rnd(32));
        rs2   = 5'(rnd(32));
        f3    = 3'(rnd(8));
        imm12 = 12'(rnd(4096));
        case (rnd(10))
            0, 1: w = {((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'h20 : 7'h00,
                       rs2, rs1, f3, rd, 7'b0110011};
            2, 3: begin
                if (f3 == 3'd1) imm12 = {7'h00, rs2};                      // SLLI
                if (f3 == 3'd5) imm12 = {(rnd(2) == 1) ? 7'h20 : 7'h00, rs2};  // SRLI or SRAI
                w = {imm12, rs1, f3, rd, 7'b0010011};
            end
            4: w = {12'(rnd(16) * 4), 5'd0, 3'b010, rd, 7'b0000011};   // LW off x0
            5: begin
                imm12 = 12'(rnd(16) * 4);                                  // SW off x0
                w = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], 7'b0100011};
            end
            6: begin
                f3    = (f3 == 3'd2 || f3 == 3'd3) ? f3 + 3'd2 : f3;      // Skip reserved kinds
                imm13 = {12'(rnd(4096)), 1'b0};
                w = {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], 7'b1100011};
            end
            7: begin
                imm21 = {20'(rnd(1 << 20)), 1'b0};
                w = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, 7'b1101111};
            end
            8:       w = {imm12, 5'd31, 3'b000, rd, 7'b1100111};             // JALR off x31
            default: w = {20'(rnd(32'hffff_ffff)), rd,
                          (rnd(2) == 1) ? 7'b0110111 : 7'b0010111};          // LUI or AUIPC
        endcase
        return w;
    endfunction

    task automatic check_retire();
        logic [31:0] pc, insn, a, b, imm_i, res, next, mem_addr;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        we, mem_we, taken;
        assert (ret_credits > 0) else flow_error("retire_valid_o with no retire credit left");
        ret_credits--;
        if (exp_pc_q.size() == 0) begin
            flow_error("retire record with no instruction outstanding");
            return;
        end
        pc       = exp_pc_q.pop_front();
        insn     = exp_insn_q.pop_front();
        rd       = insn[11:7];
        f3       = insn[14:12];
        a        = mregs[insn[19:15]];
        b        = mregs[insn[24:20]];
        imm_i    = {{20{insn[31]}}, insn[31:20]};
        next     = pc + 4;
        we       = 1'b1;
        mem_we   = 1'b0;
        res      = '0;
        mem_addr = '0;
        case (f3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            3'b110:  taken = (a < b);
            3'b111:  taken = (a >= b);
            default: taken = 1'b0;
        endcase
        case (insn[6:0])
            7'b0110011: res = alu_ref(f3, insn[30], a, b);
            7'b0010011: res = alu_ref(f3, insn[30] && f3 == 3'b101, a, imm_i);  // No SUBI
            7'b0000011: begin
                mem_addr = a + imm_i;
                res      = mmem[mem_addr[MAW+1:2]];
            end
            7'b0100011: begin
                we       = 1'b0;
                mem_we   = 1'b1;
                mem_addr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
                mmem[mem_addr[MAW+1:2]] = b;
            end
            7'b1100011: begin
                we = 1'b0;
                if (taken) next = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25],
                                        insn[11:8], 1'b0};
            end
            7'b1101111: begin
                res  = pc + 4;
                next = pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
            end
            7'b1100111: begin
                res  = pc + 4;
                next = (a + imm_i) & ~32'd1;
            end
            7'b0110111: res = {insn[31:12], 12'h000};
            7'b0010111: res = pc + {insn[31:12], 12'h000};
            default:    we = 1'b0;
        endcase
        check_word(pc, "retire_pc_o", retire_pc_o, pc);
        check_word(pc, "retire_next_pc_o", retire_next_pc_o, next);
        check_word(pc, "retire_we_o", 32'(retire_we_o), 32'(we));
        check_word(pc, "retire_mem_we_o", 32'(retire_mem_we_o), 32'(mem_we));
        if (we) begin
            check_word(pc, "retire_rd_o", 32'(retire_rd_o), 32'(rd));
            check_word(pc, "retire_wdata_o", retire_wdata_o, res);
            if (rd != 5'd0) mregs[rd] = res;  // x0 stays zero
        end
        if (mem_we) begin
            check_word(pc, "retire_mem_addr_o", retire_mem_addr_o, mem_addr & ~32'd3);
            check_word(pc, "retire_mem_wdata_o", retire_mem_wdata_o, b);
        end
        retired++;
    endtask

    task automatic return_credit();
        if (credit_dly.size() > 0 && credit_dly[0] == 0) begin
            void'(credit_dly.pop_front());
            retire_credit_i <= 1'b1;
        end else begin
            if (credit_dly.size() > 0) credit_dly[0] = credit_dly[0] - 1;
            retire_credit_i <= 1'b0;
        end
    endtask

    task automatic issue_insn();
        int          credits;
        logic [31:0] word;
        if (insn_credit_o) begin
            assert (in_credits < DEPTH) else flow_error("more input credits returned than sent");
        end
        credits = in_credits + (insn_credit_o ? 1 : 0);
        if (idle_cycles < 4 || issued == N_INSNS || credits == 0) begin
            insn_valid_i <= 1'b0;  // Idle after reset, done, or out of credit
        end else begin
            word = (issued == 0) ? LUI_X31 : gen_insn();
            insn_valid_i <= 1'b1;
            insn_pc_i    <= fetch_pc;
            insn_i       <= word;
            exp_pc_q.push_back(fetch_pc);
            exp_insn_q.push_back(word);
            fetch_pc = fetch_pc + 4;
            issued++;
            credits--;
        end
        idle_cycles++;
        in_credits = credits;
    endtask

    always @(posedge clk) begin
        if (reset_i) begin
            in_credits  = DEPTH;
            ret_credits = RET;
            issued      = 0;
            retired     = 0;
            idle_cycles = 0;
            seen_accept = 1'b0;
            fetch_pc    = 32'h0000_0100;
            exp_pc_q.delete();
            exp_insn_q.delete();
            credit_dly.delete();
            for (int i = 0; i < 32; i++) begin
                mregs[i] = '0;
            end
            for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
                mmem[i] = '0;
            end
            insn_valid_i    <= 1'b0;
            retire_credit_i <= 1'b0;
        end else begin
            if (!seen_accept) begin
                assert (!retire_valid_o && !insn_credit_o)
                    else flow_error("retire or credit pulse before the first instruction");
            end
            if (insn_valid_i) seen_accept = 1'b1;
            if (retire_credit_i) ret_credits++;  // Credit seen by the core at this edge
            if (retire_valid_o) check_retire();
            return_credit();
            if (retire_valid_o) credit_dly.push_back(int'(rnd(4)));  // 0 to 3 cycles
            issue_insn();
        end
    end

    initial begin
        int cyc;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        cyc = 0;
        while (retired < N_INSNS && cyc < N_INSNS * 20) begin
            @(posedge clk);
            cyc++;
        end
        if (retired < N_INSNS) begin
            timeout_errs++;
            $display("Timeout: only %0d of %0d instructions retired", retired, N_INSNS);
        end
        cyc = 0;
        while ((in_credits != DEPTH || ret_credits != RET || credit_dly.size() != 0)
               && cyc < 100) begin
            @(posedge clk);
            cyc++;
        end
        if (in_credits != DEPTH || ret_credits != RET) begin
            timeout_errs++;
            $display("Timeout: credits did not return, input %0d of %0d, retire %0d of %0d",
                     in_credits, DEPTH, ret_credits, RET);
        end
        assert (issued == retired && exp_pc_q.size() == 0)
            else flow_error("issued and retired instruction counts differ");
        $display("Errors: value %0d, flow %0d, timeout %0d", value_errs, flow_errs,
                 timeout_errs);
        if (value_errs + flow_errs + timeout_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_core_top

//--- core_top.sv
`timescale 1ns/100ps
// RV32I decode and execute core, no fetch
// Input and retire streams are credit based, see the port groups below
`include "core_settings.svh"

module core_top import rv32i_isa_pkg::*, core_pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  insn_valid_i,        // Sender holds a credit
    input  logic [`CORE_XLEN-1:0] insn_pc_i,
    input  logic [`CORE_XLEN-1:0] insn_i,
    output logic                  insn_credit_o,       // One credit back per pop
    output logic                  retire_valid_o,
    output logic [`CORE_XLEN-1:0] retire_pc_o,
    output logic [`CORE_XLEN-1:0] retire_next_pc_o,
    output logic [4:0]            retire_rd_o,
    output logic                  retire_we_o,
    output logic [`CORE_XLEN-1:0] retire_wdata_o,
    output logic                  retire_mem_we_o,
    output logic [`CORE_XLEN-1:0] retire_mem_addr_o,
    output logic [`CORE_XLEN-1:0] retire_mem_wdata_o,
    input  logic                  retire_credit_i      // One per record consumed
);

    insn_rec_t             head_rec;
    logic                  head_valid, pop;
    logic [6:0]            opcode, funct7;
    logic [2:0]            funct3;
    logic [4:0]            rs1, rs2, rd, rf_rd;
    logic [`CORE_XLEN-1:0] imm, rs1_data, rs2_data, rf_wdata;
    logic                  pcsel, regwren, rs1sel, rs2sel, memwren, rf_we;
    wb_sel_e               wbsel;
    alu_op_e               alusel;

    insn_buffer u_insn_buffer (
        .clk, .reset_i,
        .push_i       (insn_valid_i),
        .push_rec_i   ({insn_pc_i, insn_i}),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_rec_o   (head_rec),
        .credit_o     (insn_credit_o)
    );

    decode u_decode (
        .insn_i (head_rec.insn), .opcode_o (opcode), .funct3_o (funct3),
        .funct7_o (funct7), .rs1_o (rs1), .rs2_o (rs2), .rd_o (rd), .imm_o (imm)
    );

    control u_control (
        .opcode_i (opcode), .funct7_i (funct7), .funct3_i (funct3),
        .pcsel_o (pcsel), .regwren_o (regwren), .rs1sel_o (rs1sel),
        .rs2sel_o (rs2sel), .memwren_o (memwren), .wbsel_o (wbsel), .alusel_o (alusel)
    );

    regfile u_regfile (
        .clk, .reset_i,
        .rs1_i (rs1), .rs2_i (rs2), .rs1_data_o (rs1_data), .rs2_data_o (rs2_data),
        .we_i (rf_we), .rd_i (rf_rd), .wdata_i (rf_wdata)
    );

    exec_stage u_exec_stage (
        .clk, .reset_i,
        .head_valid_i (head_valid), .pc_i (head_rec.pc), .funct3_i (funct3),
        .rd_i (rd), .imm_i (imm), .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
        .pcsel_i (pcsel), .regwren_i (regwren), .rs1sel_i (rs1sel),
        .rs2sel_i (rs2sel), .memwren_i (memwren), .wbsel_i (wbsel), .alusel_i (alusel),
        .pop_o (pop), .rf_we_o (rf_we), .rf_wdata_o (rf_wdata), .rf_rd_o (rf_rd),
        .retire_valid_o, .retire_pc_o, .retire_next_pc_o, .retire_rd_o,
        .retire_we_o, .retire_wdata_o, .retire_mem_we_o, .retire_mem_addr_o,
        .retire_mem_wdata_o, .retire_credit_i
    );

endmodule : core_top

//--- exec_stage.sv
`timescale 1ns/100ps
// Execute, memory and writeback for the head instruction in one cycle
// Pops only with a retire credit in hand; the retire record is registered
// Data memory is word indexed, low address bits ignored, cleared on reset
`include "core_settings.svh"

module exec_stage import rv32i_isa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  head_valid_i,
    input  logic [`CORE_XLEN-1:0] pc_i,
    input  logic [2:0]            funct3_i,
    input  logic [4:0]            rd_i,
    input  logic [`CORE_XLEN-1:0] imm_i,
    input  logic [`CORE_XLEN-1:0] rs1_data_i,
    input  logic [`CORE_XLEN-1:0] rs2_data_i,
    input  logic                  pcsel_i,
    input  logic                  regwren_i,
    input  logic                  rs1sel_i,
    input  logic                  rs2sel_i,
    input  logic                  memwren_i,
    input  wb_sel_e               wbsel_i,
    input  alu_op_e               alusel_i,
    output logic                  pop_o,
    output logic                  rf_we_o,
    output logic [`CORE_XLEN-1:0] rf_wdata_o,
    output logic [4:0]            rf_rd_o,
    output logic                  retire_valid_o,
    output logic [`CORE_XLEN-1:0] retire_pc_o,
    output logic [`CORE_XLEN-1:0] retire_next_pc_o,
    output logic [4:0]            retire_rd_o,
    output logic                  retire_we_o,
    output logic [`CORE_XLEN-1:0] retire_wdata_o,
    output logic                  retire_mem_we_o,
    output logic [`CORE_XLEN-1:0] retire_mem_addr_o,
    output logic [`CORE_XLEN-1:0] retire_mem_wdata_o,
    input  logic                  retire_credit_i
);

    localparam int MAW = $clog2(`CORE_DMEM_WORDS);
    localparam int CCW = $clog2(`CORE_RET_CREDITS + 1);

    logic [`CORE_XLEN-1:0] op_a, op_b, alu_res, pc_plus4, next_pc, ld_data;
    logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_WORDS];
    logic [MAW-1:0]        widx;     // Word index into data memory
    logic [CCW-1:0]        ret_cnt;  // Retire credits left
    logic                  taken;

    assign pop_o = head_valid_i && (ret_cnt != '0);
    assign op_a  = rs1sel_i ? pc_i : rs1_data_i;
    assign op_b  = rs2sel_i ? imm_i : rs2_data_i;

    alu u_alu (
        .op_i     (alusel_i),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_res)
    );

    always_comb begin
        case (funct3_i)
            FUNCT3_BEQ:  taken = (rs1_data_i == rs2_data_i);
            FUNCT3_BNE:  taken = (rs1_data_i != rs2_data_i);
            FUNCT3_BLT:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            FUNCT3_BGE:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            FUNCT3_BLTU: taken = (rs1_data_i < rs2_data_i);
            FUNCT3_BGEU: taken = (rs1_data_i >= rs2_data_i);
            default:     taken = 1'b0;  // Reserved funct3
        endcase
    end

    assign pc_plus4 = pc_i + 32'd4;

    always_comb begin
        next_pc = pc_plus4;
        if (pcsel_i && wbsel_i == WB_PC4) begin
            next_pc = {alu_res[`CORE_XLEN-1:1], 1'b0};  // JAL and JALR target
        end else if (pcsel_i && taken) begin
            next_pc = pc_i + imm_i;                     // Taken branch
        end
    end

    assign widx    = alu_res[MAW+1:2];
    assign ld_data = dmem[widx];

    always_comb begin
        case (wbsel_i)
            WB_MEM:  rf_wdata_o = ld_data;
            WB_PC4:  rf_wdata_o = pc_plus4;
            default: rf_wdata_o = alu_res;
        endcase
    end

    assign rf_we_o = pop_o && regwren_i;
    assign rf_rd_o = rd_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `CORE_DMEM_WORDS; i++) dmem[i] <= '0;
        end else if (pop_o && memwren_i) begin
            dmem[widx] <= rs2_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retire_valid_o <= 1'b0;
            ret_cnt        <= CCW'(`CORE_RET_CREDITS);
        end else begin
            retire_valid_o <= pop_o;
            ret_cnt        <= ret_cnt - CCW'(pop_o) + CCW'(retire_credit_i);
        end
    end

    // Retire payload, qualified by retire_valid_o
    always_ff @(posedge clk) begin
        if (pop_o) begin
            retire_pc_o        <= pc_i;
            retire_next_pc_o   <= next_pc;
            retire_rd_o        <= rd_i;
            retire_we_o        <= regwren_i;
            retire_wdata_o     <= rf_wdata_o;
            retire_mem_we_o    <= memwren_i;
            retire_mem_addr_o  <= {alu_res[`CORE_XLEN-1:2], 2'b00};  // Word aligned
            retire_mem_wdata_o <= rs2_data_i;
        end
    end

endmodule : exec_stage

//--- alu.sv
`timescale 1ns/100ps
// Combinational ALU; shifts use the low five bits of b
`include "core_settings.svh"

module alu import rv32i_isa_pkg::*; (
    input  alu_op_e               op_i,
    input  logic [`CORE_XLEN-1:0] a_i,
    input  logic [`CORE_XLEN-1:0] b_i,
    output logic [`CORE_XLEN-1:0] result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_SUB:   result_o = a_i - b_i;
            ALU_AND:   result_o = a_i & b_i;
            ALU_OR:    result_o = a_i | b_i;
            ALU_XOR:   result_o = a_i ^ b_i;
            ALU_SLL:   result_o = a_i << shamt;
            ALU_SRL:   result_o = a_i >> shamt;
            ALU_SRA:   result_o = $signed(a_i) >>> shamt;
            ALU_SLT:   result_o = `CORE_XLEN'($signed(a_i) < $signed(b_i));
            ALU_SLTU:  result_o = `CORE_XLEN'(a_i < b_i);
            ALU_LUI:   result_o = b_i;        // Upper immediate as is
            ALU_AUIPC: result_o = a_i + b_i;  // a is the pc here
            default:   result_o = a_i + b_i;  // ADD
        endcase
    end

endmodule : alu

//--- regfile.sv
`timescale 1ns/100ps
// Register file with two asynchronous reads and one synchronous write
// x0 reads as zero; no write bypass, a write is visible the cycle after
`include "core_settings.svh"

module regfile #(
    parameter int AW = $clog2(`CORE_NREGS)
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [AW-1:0]         rs1_i,
    input  logic [AW-1:0]         rs2_i,
    output logic [`CORE_XLEN-1:0] rs1_data_o,
    output logic [`CORE_XLEN-1:0] rs2_data_o,
    input  logic                  we_i,
    input  logic [AW-1:0]         rd_i,
    input  logic [`CORE_XLEN-1:0] wdata_i
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `CORE_NREGS; i++) regs[i] <= '0;
        end else if (we_i && rd_i != '0) begin  // x0 stays zero
            regs[rd_i] <= wdata_i;
        end
    end

endmodule : regfile

//--- control.sv
`timescale 1ns/100ps
// Control bit decoder, purely combinational
// pcsel_o marks a pc redirect candidate: always for jumps, on compare for branches
// rs1sel_o picks the pc, rs2sel_o picks the immediate
// Unknown opcodes produce no register or memory write

module control import rv32i_isa_pkg::*; (
    input  logic [6:0] opcode_i,
    input  logic [6:0] funct7_i,
    input  logic [2:0] funct3_i,
    output logic       pcsel_o,
    output logic       regwren_o,
    output logic       rs1sel_o,
    output logic       rs2sel_o,
    output logic       memwren_o,
    output wb_sel_e    wbsel_o,
    output alu_op_e    alusel_o
);

    alu_op_e arith_op;  // Operation from funct3 and funct7

    always_comb begin
        case (funct3_i)
            FUNCT3_ADD_SUB: arith_op = ALU_ADD;
            FUNCT3_SLL:     arith_op = ALU_SLL;
            FUNCT3_SLT:     arith_op = ALU_SLT;
            FUNCT3_SLTU:    arith_op = ALU_SLTU;
            FUNCT3_XOR:     arith_op = ALU_XOR;
            FUNCT3_SRL_SRA: arith_op = (funct7_i == FUNCT7_SRA) ? ALU_SRA : ALU_SRL;
            FUNCT3_OR:      arith_op = ALU_OR;
            default:        arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        pcsel_o   = 1'b0;    // Fall through to pc + 4
        regwren_o = 1'b0;
        rs1sel_o  = 1'b0;    // rs1 data
        rs2sel_o  = 1'b0;    // rs2 data
        memwren_o = 1'b0;
        wbsel_o   = WB_ALU;
        alusel_o  = ALU_ADD;
        case (opcode_i)
            OPCODE_RTYPE: begin
                regwren_o = 1'b1;
                alusel_o  = arith_op;
                if (funct3_i == FUNCT3_ADD_SUB && funct7_i == FUNCT7_SUB) begin
                    alusel_o = ALU_SUB;
                end
            end
            OPCODE_ITYPE: begin
                regwren_o = 1'b1;
                rs2sel_o  = 1'b1;
                alusel_o  = arith_op;  // No SUBI, funct3 000 is ADDI
            end
            OPCODE_LOAD: begin
                regwren_o = 1'b1;
                rs2sel_o  = 1'b1;      // Base plus offset
                wbsel_o   = WB_MEM;
            end
            OPCODE_STORE: begin
                rs2sel_o  = 1'b1;
                memwren_o = 1'b1;
            end
            OPCODE_BRANCH: begin
                pcsel_o  = 1'b1;       // Taken only if the compare holds
                alusel_o = ALU_SUB;
            end
            OPCODE_JAL: begin
                pcsel_o   = 1'b1;
                regwren_o = 1'b1;
                rs1sel_o  = 1'b1;      // Target is pc + imm
                rs2sel_o  = 1'b1;
                wbsel_o   = WB_PC4;
            end
            OPCODE_JALR: begin
                pcsel_o   = 1'b1;
                regwren_o = 1'b1;
                rs2sel_o  = 1'b1;      // Target is rs1 + imm
                wbsel_o   = WB_PC4;
            end
            OPCODE_LUI: begin
                regwren_o = 1'b1;
                rs2sel_o  = 1'b1;
                alusel_o  = ALU_LUI;
            end
            OPCODE_AUIPC: begin
                regwren_o = 1'b1;
                rs1sel_o  = 1'b1;
                rs2sel_o  = 1'b1;
                alusel_o  = ALU_AUIPC;
            end
            default: begin
                regwren_o = 1'b0;      // Treated as a no-op
            end
        endcase
    end

endmodule : control

//--- decode.sv
`timescale 1ns/100ps
// Field extraction and immediate generation
// Immediate is zero for R-type and unknown opcodes
`include "core_settings.svh"

module decode import rv32i_isa_pkg::*, core_pipe_pkg::*; (
    input  logic [`CORE_XLEN-1:0] insn_i,
    output logic [6:0]            opcode_o,
    output logic [2:0]            funct3_o,
    output logic [6:0]            funct7_o,
    output logic [4:0]            rs1_o,
    output logic [4:0]            rs2_o,
    output logic [4:0]            rd_o,
    output logic [`CORE_XLEN-1:0] imm_o
);

    imm_fmt_e fmt;
    logic     imm_en;  // Opcode carries an immediate

    assign opcode_o = insn_i[6:0];
    assign rd_o     = insn_i[11:7];
    assign funct3_o = insn_i[14:12];
    assign rs1_o    = insn_i[19:15];
    assign rs2_o    = insn_i[24:20];
    assign funct7_o = insn_i[31:25];

    always_comb begin
        fmt    = IMM_I;
        imm_en = 1'b1;
        case (opcode_o)
            OPCODE_ITYPE, OPCODE_LOAD, OPCODE_JALR: fmt = IMM_I;
            OPCODE_STORE:                           fmt = IMM_S;
            OPCODE_BRANCH:                          fmt = IMM_B;
            OPCODE_LUI, OPCODE_AUIPC:               fmt = IMM_U;
            OPCODE_JAL:                             fmt = IMM_J;
            default:                                imm_en = 1'b0; // R-type too
        endcase
    end

    always_comb begin
        case (fmt)
            IMM_S: imm_o = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
            IMM_B: imm_o = {{19{insn_i[31]}}, insn_i[31], insn_i[7],
                            insn_i[30:25], insn_i[11:8], 1'b0};
            IMM_U: imm_o = {insn_i[31:12], 12'b0};
            IMM_J: imm_o = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12],
                            insn_i[20], insn_i[30:21], 1'b0};
            default: imm_o = {{20{insn_i[31]}}, insn_i[31:20]};  // I format
        endcase
        if (!imm_en) imm_o = '0;
    end

endmodule : decode

//--- insn_buffer.sv
`timescale 1ns/100ps
// Circular FIFO of pc and instruction pairs
// The sender must respect credits; a push into a full buffer is not checked
// credit_o is registered, one pulse per popped entry
`include "core_settings.svh"

module insn_buffer import core_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      push_i,
    input  insn_rec_t push_rec_i,
    input  logic      pop_i,
    output logic      head_valid_o,
    output insn_rec_t head_rec_o,
    output logic      credit_o
);

    localparam int DEPTH = `CORE_IN_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    insn_rec_t     mem [DEPTH];  // Entry storage
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;        // Occupied entries

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1; // Wrap for any depth
    endfunction

    assign head_valid_o = (count != '0);
    assign head_rec_o   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;                                // One credit per pop
            if (push_i) wr_ptr <= ptr_inc(wr_ptr);
            if (pop_i)  rd_ptr <= ptr_inc(rd_ptr);
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                      // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) mem[wr_ptr] <= push_rec_i;
    end

endmodule : insn_buffer

//--- core_pipe_pkg.sv
// Types shared by the pipeline blocks of the core
`include "core_settings.svh"

package core_pipe_pkg;

    // Input buffer entry, pc in the upper half
    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] insn;
    } insn_rec_t;

    // Immediate layouts of the base ISA
    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

endpackage : core_pipe_pkg

//--- rv32i_isa_pkg.sv
// RV32I encodings used by the core
// Only the base integer subset without FENCE, ECALL and CSRs
package rv32i_isa_pkg;

    localparam logic [6:0] OPCODE_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPCODE_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;

    // ALU funct3
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;
    localparam logic [6:0] FUNCT7_SRA = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'b00, // ALU result
        WB_MEM = 2'b01, // Load data
        WB_PC4 = 2'b10  // Return address
    } wb_sel_e;

endpackage : rv32i_isa_pkg

//--- core_settings.svh
// Size settings for the RV32I decode and execute core
// CORE_DMEM_WORDS must be a power of two
// CORE_IN_DEPTH is also the sender's initial credit count
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_XLEN        32  // Data and instruction width
`define CORE_NREGS       32  // Architectural registers
`define CORE_IN_DEPTH    4   // Input buffer entries
`define CORE_RET_CREDITS 2   // Retire credits held after reset
`define CORE_DMEM_WORDS  64  // Data memory words

`endif
